// File: Bender.yml
package:
  name: filter_controller

sources:
  - include_dirs:
      - .
    files:
      - filt_win_pkg.sv
      - filt_ctrl_pkg.sv
      - filt_ifs.sv
      - line_buffer.sv
      - window_regs.sv
      - window_scanner.sv
      - filt_ctrl_fsm.sv
      - filter_controller_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_filter_controller.sv

// File: compile.f
+incdir+.
filt_win_pkg.sv
filt_ctrl_pkg.sv
filt_ifs.sv
line_buffer.sv
window_regs.sv
window_scanner.sv
filt_ctrl_fsm.sv
filter_controller_top.sv
tb_clock_gen.sv
tb_filter_controller.sv

// File: filt_ctrl_fsm.sv
`default_nettype none
`timescale 1ns/10ps

`include "filt_params.svh"

module filt_ctrl_fsm import filt_ctrl_pkg::*, filt_win_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  command_t command,
    input  logic     image_ram_available,
    input  pixel_t   image_ram_rdata,
    input  pixel_t   filtered_pixel,
    input  logic     uart_ready,
    output pixel_t   uart_data,
    output logic     uart_is_new,
    scan_if.ctrl     scan,
    ram_req_if.ctrl  ram
);

    localparam image_addr_t last_xfer_addr =
        image_addr_t'(`FILT_IMAGE_WIDTH * `FILT_IMAGE_HEIGHT - 1);

    ctrl_state_t state;
    ctrl_state_t state_next;
    image_addr_t xfer_addr;
    logic        rdata_fresh;
    pixel_t      xfer_byte;
    logic        local_pixel;

    // Padding and top rows need no RAM access
    assign local_pixel = scan.outside || scan.top_rows;

    ////////////////////
    // Next state and strobes
    ////////////////////

    always_comb begin
        state_next      = state;
        ram.ce          = 1'b0;
        ram.we          = 1'b0;
        ram.addr        = ram.rd_addr;
        ram.wdata       = filtered_pixel;
        scan.fill       = 1'b0;
        scan.scan_start = 1'b0;
        uart_is_new     = 1'b0;

        case (state)
            idle: begin
                if (command == cmd_filter_and_transfer) begin
                    scan.scan_start = 1'b1;
                    state_next      = fetch_pixel;
                end
            end
            fetch_pixel: begin
                if (local_pixel) begin
                    state_next = load_pixel;
                end else if (image_ram_available) begin
                    ram.ce     = 1'b1;
                    state_next = load_pixel;
                end
            end
            load_pixel: begin
                scan.fill  = 1'b1;
                state_next = scan.win_last ? write_back : fetch_pixel;
            end
            write_back: begin
                ram.addr = ram.wr_addr;
                if (image_ram_available) begin
                    ram.ce     = 1'b1;
                    ram.we     = 1'b1;
                    state_next = scan.image_done ? xfer_read : fetch_pixel;
                end
            end
            xfer_read: begin
                ram.addr = xfer_addr;
                if (image_ram_available) begin
                    ram.ce     = 1'b1;
                    state_next = xfer_write;
                end
            end
            xfer_write: begin
                if (uart_ready) begin
                    uart_is_new = 1'b1;
                    state_next  = (xfer_addr == last_xfer_addr) ? idle : xfer_read;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            xfer_addr   <= '0;
            rdata_fresh <= 1'b0;
        end else begin
            state       <= state_next;
            rdata_fresh <= (state == xfer_read) && image_ram_available;
            if (state == xfer_write && uart_ready) begin
                if (xfer_addr == last_xfer_addr) begin
                    xfer_addr <= '0;
                end else begin
                    xfer_addr <= xfer_addr + 1'b1;
                end
            end
        end
    end

    // Hold the byte while the UART is busy
    always_ff @(posedge clk) begin
        if (rdata_fresh) begin
            xfer_byte <= image_ram_rdata;
        end
    end

    assign uart_data = rdata_fresh ? image_ram_rdata : xfer_byte;

endmodule

`default_nettype wire

// File: filt_ctrl_pkg.sv
`default_nettype none

package filt_ctrl_pkg;

    // Controller states
    typedef enum logic [2:0] {
        idle        = 3'd0,
        fetch_pixel = 3'd1,
        load_pixel  = 3'd2,
        write_back  = 3'd3,
        xfer_read   = 3'd4,
        xfer_write  = 3'd5
    } ctrl_state_t;

    // Host commands, other codes are ignored
    typedef enum logic [1:0] {
        cmd_none                = 2'd0,
        cmd_filter_and_transfer = 2'd1
    } command_t;

endpackage

`default_nettype wire

// File: filt_ifs.sv
`default_nettype none
`timescale 1ns/10ps

////////////////////
// Scan control between FSM, scanner and window
////////////////////

interface scan_if import filt_win_pkg::*; ();

    logic     fill;
    logic     scan_start;
    logic     outside;
    logic     top_rows;
    logic     win_last;
    logic     image_done;
    logic     leftmost;
    win_idx_t win_x;
    win_idx_t win_y;
    pixel_t   lb_rdata;

    modport ctrl (
        output fill, scan_start,
        input  outside, top_rows, win_last, image_done
    );

    modport scan (
        input  fill, scan_start,
        output outside, top_rows, win_last, image_done, leftmost, win_x, win_y
    );

    modport win (
        input fill, outside, top_rows, leftmost, win_x, win_y, lb_rdata
    );

endinterface

////////////////////
// Image RAM request
////////////////////

interface ram_req_if import filt_win_pkg::*; ();

    logic        ce;
    logic        we;
    image_addr_t addr;
    pixel_t      wdata;
    // Scanner side addresses and returned data
    image_addr_t rd_addr;
    image_addr_t wr_addr;
    pixel_t      rdata;

    modport ctrl (
        output ce, we, addr, wdata,
        input  rd_addr, wr_addr
    );

    modport scan (
        output rd_addr, wr_addr,
        input  rdata
    );

endinterface

`default_nettype wire

// File: filt_params.svh
`ifndef FILT_PARAMS_SVH
`define FILT_PARAMS_SVH

// Image size in pixels
`define FILT_IMAGE_WIDTH 8
`define FILT_IMAGE_HEIGHT 6

// Filter window
`define FILT_WIN_EDGE 5
`define FILT_WIN_SIZE (`FILT_WIN_EDGE * `FILT_WIN_EDGE)
`define FILT_PAD (`FILT_WIN_EDGE / 2)

`define FILT_PIXEL_WIDTH 8

// Derived index widths
`define FILT_IMAGE_ADDR_WIDTH $clog2(`FILT_IMAGE_WIDTH * `FILT_IMAGE_HEIGHT)
`define FILT_X_WIDTH $clog2(`FILT_IMAGE_WIDTH)
`define FILT_Y_WIDTH $clog2(`FILT_IMAGE_HEIGHT)
`define FILT_WIN_IDX_WIDTH $clog2(`FILT_WIN_EDGE)

`endif

// File: filt_win_pkg.sv
`default_nettype none

`include "filt_params.svh"

package filt_win_pkg;

    typedef logic [`FILT_PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [`FILT_IMAGE_ADDR_WIDTH-1:0] image_addr_t;

    // Output position
    typedef logic [`FILT_X_WIDTH-1:0] img_x_t;
    typedef logic [`FILT_Y_WIDTH-1:0] img_y_t;

    // Padded position, negative left of and above the image
    typedef logic signed [`FILT_X_WIDTH+1:0] abs_x_t;
    typedef logic signed [`FILT_Y_WIDTH+1:0] abs_y_t;

    typedef logic [`FILT_WIN_IDX_WIDTH-1:0] win_idx_t;

    // Row-major, top-left pixel in the low byte
    typedef logic [`FILT_WIN_SIZE*`FILT_PIXEL_WIDTH-1:0] window_t;

    // Bank bit above the column
    typedef logic [`FILT_X_WIDTH:0] lb_addr_t;

endpackage

`default_nettype wire

// File: filter_controller_top.sv
`default_nettype none
`timescale 1ns/10ps

module filter_controller_top import filt_ctrl_pkg::*, filt_win_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  command_t    command,
    input  logic        image_ram_available,
    input  pixel_t      image_ram_rdata,
    output logic        image_ram_ce,
    output logic        image_ram_we,
    output image_addr_t image_ram_addr,
    output pixel_t      image_ram_wdata,
    output window_t     window_pixels,
    input  pixel_t      filtered_pixel,
    input  logic        uart_ready,
    output pixel_t      uart_data,
    output logic        uart_is_new
);

    lb_addr_t lb_rd_addr;
    lb_addr_t lb_wr_addr;
    logic     lb_we;
    pixel_t   lb_wdata;

    scan_if    scan_bus ();
    ram_req_if ram_bus ();

    // RAM pins
    assign image_ram_ce    = ram_bus.ce;
    assign image_ram_we    = ram_bus.we;
    assign image_ram_addr  = ram_bus.addr;
    assign image_ram_wdata = ram_bus.wdata;
    assign ram_bus.rdata   = image_ram_rdata;

    filt_ctrl_fsm u_fsm (
        .clk                 (clk),
        .rst                 (rst),
        .command             (command),
        .image_ram_available (image_ram_available),
        .image_ram_rdata     (image_ram_rdata),
        .filtered_pixel      (filtered_pixel),
        .uart_ready          (uart_ready),
        .uart_data           (uart_data),
        .uart_is_new         (uart_is_new),
        .scan                (scan_bus.ctrl),
        .ram                 (ram_bus.ctrl)
    );

    window_scanner u_scanner (
        .clk        (clk),
        .rst        (rst),
        .scan       (scan_bus.scan),
        .ram        (ram_bus.scan),
        .lb_rd_addr (lb_rd_addr),
        .lb_wr_addr (lb_wr_addr),
        .lb_we      (lb_we),
        .lb_wdata   (lb_wdata)
    );

    window_regs u_window (
        .clk           (clk),
        .rst           (rst),
        .scan          (scan_bus.win),
        .pixel_in      (image_ram_rdata),
        .window_pixels (window_pixels)
    );

    line_buffer u_line_buffer (
        .clk     (clk),
        .we      (lb_we),
        .wr_addr (lb_wr_addr),
        .wdata   (lb_wdata),
        .rd_addr (lb_rd_addr),
        .rdata   (scan_bus.lb_rdata)
    );

endmodule

`default_nettype wire

// File: line_buffer.sv
`default_nettype none
`timescale 1ns/10ps

`include "filt_params.svh"

module line_buffer import filt_win_pkg::*; (
    input  logic     clk,
    input  logic     we,
    input  lb_addr_t wr_addr,
    input  pixel_t   wdata,
    input  lb_addr_t rd_addr,
    output pixel_t   rdata
);

    // One image row per bank, selected by row parity
    pixel_t bank_mem [2][`FILT_IMAGE_WIDTH];

    always_ff @(posedge clk) begin
        if (we) begin
            bank_mem[wr_addr[`FILT_X_WIDTH]][wr_addr[`FILT_X_WIDTH-1:0]] <= wdata;
        end
        rdata <= bank_mem[rd_addr[`FILT_X_WIDTH]][rd_addr[`FILT_X_WIDTH-1:0]];
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_filter_controller.sv
`default_nettype none
`timescale 1ns/10ps

`include "filt_params.svh"

module tb_filter_controller import filt_ctrl_pkg::*, filt_win_pkg::*; ();

    localparam int img_w = `FILT_IMAGE_WIDTH;
    localparam int img_h = `FILT_IMAGE_HEIGHT;
    localparam int npix = img_w * img_h;
    localparam int num_tests = 8;
    localparam int watchdog_cycles = num_tests * npix * 200;

    typedef enum logic [1:0] {pat_ramp, pat_random, pat_white} pattern_t;

    typedef struct packed {
        pattern_t   pattern;
        logic [7:0] ram_stall_pct;
        logic [7:0] uart_stall_pct;
        logic       mid_command;
    } test_entry_t;

    logic        clk;
    logic        rst;
    command_t    command;
    logic        image_ram_available;
    pixel_t      image_ram_rdata;
    logic        image_ram_ce;
    logic        image_ram_we;
    image_addr_t image_ram_addr;
    pixel_t      image_ram_wdata;
    window_t     window_pixels;
    pixel_t      filtered_pixel;
    logic        uart_ready;
    pixel_t      uart_data;
    logic        uart_is_new;

    test_entry_t test_table [num_tests];
    pixel_t      image_mem [npix];
    pixel_t      orig_image [npix];
    pixel_t      random_image [npix];
    pixel_t      exp_filt [npix];
    pixel_t      rx_bytes [npix];
    pixel_t      ref_result [3][npix];
    logic        ref_valid [3];
    int          seed;
    int          wb_count;
    int          rx_count;
    int          ram_stall_pct;
    int          uart_stall_pct;
    logic        read_pending;
    image_addr_t read_addr;

    tb_clock_gen clock_gen0 (
        .clk (clk),
        .rst (rst)
    );

    filter_controller_top dut0 (
        .clk                 (clk),
        .rst                 (rst),
        .command             (command),
        .image_ram_available (image_ram_available),
        .image_ram_rdata     (image_ram_rdata),
        .image_ram_ce        (image_ram_ce),
        .image_ram_we        (image_ram_we),
        .image_ram_addr      (image_ram_addr),
        .image_ram_wdata     (image_ram_wdata),
        .window_pixels       (window_pixels),
        .filtered_pixel      (filtered_pixel),
        .uart_ready          (uart_ready),
        .uart_data           (uart_data),
        .uart_is_new         (uart_is_new)
    );

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
            $display("tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic pixel_t padded_pixel(input int x, input int y);
        if (x < 0 || y < 0 || x >= img_w || y >= img_h) begin
            return '0;
        end
        return orig_image[y*img_w+x];
    endfunction

    // Window sum modulo 256 of the zero-padded original
    task automatic compute_expected();
        int sum;
        for (int y = 0; y < img_h; y++) begin
            for (int x = 0; x < img_w; x++) begin
                sum = 0;
                for (int wy = 0; wy < `FILT_WIN_EDGE; wy++) begin
                    for (int wx = 0; wx < `FILT_WIN_EDGE; wx++) begin
                        sum = sum + padded_pixel(x + wx - `FILT_PAD, y + wy - `FILT_PAD);
                    end
                end
                exp_filt[y*img_w+x] = pixel_t'(sum);
            end
        end
    endtask

    task automatic check_idle_outputs(input string when);
        check_value({"image_ram_ce ", when}, image_ram_ce, 0);
        check_value({"image_ram_we ", when}, image_ram_we, 0);
        check_value({"uart_is_new ", when}, uart_is_new, 0);
        check_value({"window not zero ", when}, window_pixels != '0, 0);
    endtask

    task automatic check_write_back();
        int x;
        int y;
        int idx;
        idx = wb_count;
        check_value("write-back beyond the image", idx < npix, 1);
        x = idx % img_w;
        y = idx / img_w;
        check_value("write-back address", image_ram_addr, idx);
        check_value("write data vs filter output", image_ram_wdata, filtered_pixel);
        check_value($sformatf("write data at %0d", idx), image_ram_wdata, exp_filt[idx]);
        for (int wy = 0; wy < `FILT_WIN_EDGE; wy++) begin
            for (int wx = 0; wx < `FILT_WIN_EDGE; wx++) begin
                check_value($sformatf("window pixel %0d,%0d at position %0d", wx, wy, idx),
                    window_pixels[(wy*`FILT_WIN_EDGE+wx)*`FILT_PIXEL_WIDTH +: `FILT_PIXEL_WIDTH],
                    padded_pixel(x + wx - `FILT_PAD, y + wy - `FILT_PAD));
            end
        end
    endtask

    ////////////////////
    // Models
    ////////////////////

    // External filter
    always_comb begin
        filtered_pixel = '0;
        for (int i = 0; i < `FILT_WIN_SIZE; i++) begin
            filtered_pixel = filtered_pixel
                + window_pixels[i*`FILT_PIXEL_WIDTH +: `FILT_PIXEL_WIDTH];
        end
    end

    // Back-pressure levels
    initial begin
        image_ram_available = 1'b1;
        uart_ready = 1'b1;
        forever begin
            @(negedge clk);
            image_ram_available = ({$random(seed)} % 100) >= ram_stall_pct;
            uart_ready = ({$random(seed)} % 100) >= uart_stall_pct;
        end
    end

    always @(posedge clk) begin
        read_pending <= 1'b0;
        if (image_ram_ce) begin
            check_value("RAM strobe while unavailable", image_ram_available, 1);
            check_value("RAM address outside the image", image_ram_addr < npix, 1);
            if (image_ram_we) begin
                check_write_back();
                image_mem[image_ram_addr] = image_ram_wdata;
                wb_count = wb_count + 1;
            end else begin
                read_pending <= 1'b1;
                read_addr <= image_ram_addr;
            end
        end
    end

    // Read data for the cycle after the strobe
    initial begin
        image_ram_rdata = '0;
        forever begin
            @(negedge clk);
            if (read_pending) begin
                image_ram_rdata = image_mem[read_addr];
            end
        end
    end

    // UART receiver
    always @(posedge clk) begin
        if (uart_is_new) begin
            check_value("uart_is_new while uart_ready low", uart_ready, 1);
            check_value("UART byte beyond the image", rx_count < npix, 1);
            check_value($sformatf("UART byte %0d", rx_count), uart_data, exp_filt[rx_count]);
            rx_bytes[rx_count] = uart_data;
            rx_count = rx_count + 1;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the DUT did not finish all tests within %0d cycles", watchdog_cycles);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // Test sequence
    ////////////////////

    task automatic run_entry(input int e, input test_entry_t entry);
        int p;
        p = int'(entry.pattern);
        @(negedge clk);
        for (int i = 0; i < npix; i++) begin
            case (entry.pattern)
                pat_ramp:   image_mem[i] = pixel_t'(i * 7 + 3 + (i >> 8));
                pat_random: image_mem[i] = random_image[i];
                default:    image_mem[i] = 8'hff;
            endcase
            orig_image[i] = image_mem[i];
        end
        compute_expected();
        wb_count = 0;
        rx_count = 0;
        ram_stall_pct <= entry.ram_stall_pct;
        uart_stall_pct <= entry.uart_stall_pct;
        command = cmd_filter_and_transfer;
        @(negedge clk);
        command = cmd_none;
        // Ignored while busy, given once the first row is written
        if (entry.mid_command) begin
            while (wb_count < img_w) @(negedge clk);
            command = cmd_filter_and_transfer;
            @(negedge clk);
            command = cmd_none;
        end
        while (rx_count < npix) @(negedge clk);
        check_value("write-back count", wb_count, npix);
        if (entry.ram_stall_pct == 0 && entry.uart_stall_pct == 0) begin
            for (int i = 0; i < npix; i++) begin
                ref_result[p][i] = rx_bytes[i];
            end
            ref_valid[p] = 1'b1;
        end else if (ref_valid[p]) begin
            for (int i = 0; i < npix; i++) begin
                check_value($sformatf("byte %0d vs stall-free run", i), rx_bytes[i],
                            ref_result[p][i]);
            end
        end
        ram_stall_pct <= 0;
        uart_stall_pct <= 0;
        $display("test %0d finished at %0t", e, $time);
    endtask

    initial begin : main_sequence
        seed = 16885;
        command = cmd_none;
        ram_stall_pct = 0;
        uart_stall_pct = 0;
        wb_count = 0;
        rx_count = 0;
        for (int p = 0; p < 3; p++) begin
            ref_valid[p] = 1'b0;
        end

        // pattern, RAM stall %, UART stall %, command during pass
        test_table[0] = '{pat_ramp,   8'd0,  8'd0,  1'b0};
        test_table[1] = '{pat_random, 8'd0,  8'd0,  1'b0};
        test_table[2] = '{pat_white,  8'd0,  8'd0,  1'b0};
        test_table[3] = '{pat_random, 8'd30, 8'd0,  1'b1};
        test_table[4] = '{pat_random, 8'd0,  8'd40, 1'b0};
        test_table[5] = '{pat_ramp,   8'd50, 8'd50, 1'b1};
        test_table[6] = '{pat_white,  8'd20, 8'd20, 1'b0};
        test_table[7] = '{pat_random, 8'd25, 8'd25, 1'b0};

        for (int i = 0; i < npix; i++) begin
            random_image[i] = pixel_t'($random(seed));
        end

        @(posedge clk);
        do begin
            @(posedge clk);
            check_idle_outputs("during reset");
        end while (rst);
        @(posedge clk);
        check_idle_outputs("after reset");

        for (int e = 0; e < num_tests; e++) begin
            run_entry(e, test_table[e]);
        end

        // Catch stray writes or bytes
        repeat (20) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: window_regs.sv
`default_nettype none
`timescale 1ns/10ps

`include "filt_params.svh"

module window_regs import filt_win_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    scan_if.win     scan,
    input  pixel_t  pixel_in,
    output window_t window_pixels
);

    pixel_t win [`FILT_WIN_SIZE];
    pixel_t pixel_sel;
    logic   shift;

    // Zero padding, old rows from the line buffer, else RAM data
    always_comb begin
        if (scan.outside) begin
            pixel_sel = '0;
        end else if (scan.top_rows) begin
            pixel_sel = scan.lb_rdata;
        end else begin
            pixel_sel = pixel_in;
        end
    end

    // First fill of a window that reuses the previous one
    assign shift = !scan.leftmost && (scan.win_y == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FILT_WIN_SIZE; i++) begin
                win[i] <= '0;
            end
        end else if (scan.fill) begin
            if (shift) begin
                for (int r = 0; r < `FILT_WIN_EDGE; r++) begin
                    for (int c = 0; c < `FILT_WIN_EDGE - 1; c++) begin
                        win[r*`FILT_WIN_EDGE+c] <= win[r*`FILT_WIN_EDGE+c+1];
                    end
                end
            end
            win[scan.win_y*`FILT_WIN_EDGE+scan.win_x] <= pixel_sel;
        end
    end

    always_comb begin
        for (int i = 0; i < `FILT_WIN_SIZE; i++) begin
            window_pixels[i*`FILT_PIXEL_WIDTH +: `FILT_PIXEL_WIDTH] = win[i];
        end
    end

endmodule

`default_nettype wire

// File: window_scanner.sv
`default_nettype none
`timescale 1ns/10ps

`include "filt_params.svh"

module window_scanner import filt_win_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    scan_if.scan     scan,
    ram_req_if.scan  ram,
    output lb_addr_t lb_rd_addr,
    output lb_addr_t lb_wr_addr,
    output logic     lb_we,
    output pixel_t   lb_wdata
);

    localparam win_idx_t edge_last = win_idx_t'(`FILT_WIN_EDGE - 1);
    localparam img_x_t x_last = img_x_t'(`FILT_IMAGE_WIDTH - 1);
    localparam img_y_t y_last = img_y_t'(`FILT_IMAGE_HEIGHT - 1);

    win_idx_t    win_x;
    win_idx_t    win_y;
    img_x_t      img_x;
    img_y_t      img_y;
    logic        done_q;
    logic        win_last;
    logic        leftmost;
    image_addr_t wb_addr;
    abs_x_t      abs_x;
    abs_y_t      abs_y;
    lb_addr_t    lb_addr;

    assign leftmost = (img_x == '0);
    assign win_last = (win_x == edge_last) && (win_y == edge_last);

    // Absolute pixel under the current window slot
    assign abs_x = abs_x_t'(img_x) + abs_x_t'(win_x) - abs_x_t'(`FILT_PAD);
    assign abs_y = abs_y_t'(img_y) + abs_y_t'(win_y) - abs_y_t'(`FILT_PAD);

    assign scan.outside = (abs_x < 0) || (abs_y < 0) ||
                          (abs_x >= `FILT_IMAGE_WIDTH) || (abs_y >= `FILT_IMAGE_HEIGHT);
    assign scan.top_rows   = (win_y < `FILT_PAD);
    assign scan.win_last   = win_last;
    assign scan.image_done = done_q;
    assign scan.leftmost   = leftmost;
    assign scan.win_x      = win_x;
    assign scan.win_y      = win_y;

    assign ram.rd_addr = image_addr_t'(abs_y * `FILT_IMAGE_WIDTH + abs_x);
    assign ram.wr_addr = wb_addr;

    // Bank follows the row parity
    assign lb_addr    = {abs_y[0], abs_x[`FILT_X_WIDTH-1:0]};
    assign lb_rd_addr = lb_addr;
    assign lb_wr_addr = lb_addr;
    assign lb_we      = scan.fill && !scan.outside && (win_y == `FILT_PAD);
    assign lb_wdata   = ram.rdata;

    ////////////////////
    // Window and image counters
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst || scan.scan_start) begin
            win_x  <= '0;
            win_y  <= '0;
            img_x  <= '0;
            img_y  <= '0;
            done_q <= 1'b0;
        end else if (scan.fill) begin
            if (win_last) begin
                win_y  <= '0;
                done_q <= (img_x == x_last) && (img_y == y_last);
                if (img_x == x_last) begin
                    win_x <= '0;
                    img_x <= '0;
                    img_y <= (img_y == y_last) ? '0 : img_y + 1'b1;
                end else begin
                    img_x <= img_x + 1'b1;
                end
            end else if (win_x == edge_last) begin
                win_y <= win_y + 1'b1;
                if (leftmost) begin
                    win_x <= '0;
                end
            end else begin
                win_x <= win_x + 1'b1;
            end
        end
    end

    // Write-back address of the position just completed
    always_ff @(posedge clk) begin
        if (scan.fill && win_last) begin
            wb_addr <= image_addr_t'(img_y * `FILT_IMAGE_WIDTH + img_x);
        end
    end

endmodule

`default_nettype wire
